// File: build.f
+incdir+rtl
rtl/sdr_ctrl_pkg.sv
rtl/ovfl_monitor.sv
rtl/ctrl_status_regs.sv
rtl/axil_reg_port.sv
rtl/sdr_ctrl_top.sv
verif/sdr_ctrl_asserts.sv
verif/tb_sdr_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the sdr control testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_sdr_ctrl -f build.f -o tb_sdr_ctrl
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

./obj_dir/tb_sdr_ctrl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: verif/tb_sdr_ctrl.sv
//////////////////////////////
// table driven testbench for the sdr host control block
// inputs change on the rising edge, outputs are sampled on the falling edge
// stops at the first mismatch, each wait gives up after 50 cycles
//////////////////////////////

`timescale 1ns/10ps

`include "sdr_ctrl_params.svh"

module tb_sdr_ctrl;

    localparam int TIMEOUT  = 50;
    localparam int MAX_ROWS = 48;

    // table operations
    localparam int OP_WR  = 0;
    localparam int OP_RD  = 1;
    localparam int OP_OVF = 2;
    localparam int OP_SRQ = 3;

    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;

    // status word with the sticky flag clear, flag sits in bit 15
    localparam logic [31:0] ID_WORD  = {16'h0000, 4'b0000, `SDR_FPGA_VER,
                                        `SDR_CLOCK_ID, `SDR_FPGA_ID};
    localparam logic [31:0] FLAG_BIT = 32'h0000_8000;

    logic                   cpu_clk;
    logic                   rx_ovfl_rst;
    logic                   awvalid;
    logic                   awready;
    logic [`SDR_ADDR_W-1:0] awaddr;
    logic                   wvalid;
    logic                   wready;
    logic [`SDR_DATA_W-1:0] wdata;
    logic [3:0]             wstrb;
    logic                   bvalid;
    logic                   bready;
    logic [1:0]             bresp;
    logic                   arvalid;
    logic                   arready;
    logic [`SDR_ADDR_W-1:0] araddr;
    logic                   rvalid;
    logic                   rready;
    logic [`SDR_DATA_W-1:0] rdata;
    logic [1:0]             rresp;
    logic                   adc_ovfl;
    logic                   host_srq;
    logic                   adc_clken;
    logic                   eeprom_wp;
    logic                   irq;

    // stimulus table
    int          row_op    [MAX_ROWS];
    logic [4:0]  row_addr  [MAX_ROWS];
    logic [31:0] row_wdata [MAX_ROWS];
    logic [31:0] row_exp   [MAX_ROWS];
    logic [1:0]  row_resp  [MAX_ROWS];
    int          n_rows;

    // reference state kept by the testbench
    logic [15:0] ctrl_model;
    int          ovfl_pulses;
    logic        srq_pending;
    integer      seed;
    int          error_count;

    sdr_ctrl_top dut_i (.*);

    // 8 ns period
    always #4 cpu_clk = ~cpu_clk;

    ////////////////////////////// reporting

    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "simulation stopped on first failure");
    endtask

    task automatic report_error(input string msg);
        error_count = error_count + 1;
        $display("error at %0t ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic report_timeout(input string what);
        $display("timeout after %0d cycles waiting for %s", TIMEOUT, what);
        stop_run();
    endtask

    // control outputs follow bits 0 to 2 of the last CTRL write
    task automatic check_outputs();
        assert (adc_clken == ctrl_model[`SDR_CTRL_OSC_EN] &&
                eeprom_wp == ctrl_model[`SDR_CTRL_EEPROM_WP] &&
                irq == ctrl_model[`SDR_CTRL_INTERRUPT])
        else report_error($sformatf("outputs irq/wp/clken %b%b%b expected %b",
                                    irq, eeprom_wp, adc_clken, ctrl_model[2:0]));
    endtask

    task automatic add_row(input int op, input logic [4:0] addr, input logic [31:0] data,
                           input logic [31:0] exp, input logic [1:0] resp);
        row_op[n_rows]    = op;
        row_addr[n_rows]  = addr;
        row_wdata[n_rows] = data;
        row_exp[n_rows]   = exp;
        row_resp[n_rows]  = resp;
        n_rows = n_rows + 1;
    endtask

    ////////////////////////////// bus tasks

    task automatic axi_write(input logic [4:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp);
        int         cnt;
        int         delay;
        logic [1:0] resp_seen;
        @(posedge cpu_clk);
        awvalid <= 1'b1;
        awaddr  <= addr;
        wvalid  <= 1'b1;
        wdata   <= data;
        // readies high on the falling edge, so acceptance on the next rising edge
        cnt = 0;
        @(negedge cpu_clk);
        while (!(awready && wready))
        begin
            cnt = cnt + 1;
            if (cnt > TIMEOUT)
                report_timeout("awready and wready");
            @(negedge cpu_clk);
        end
        @(posedge cpu_clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        cnt = 0;
        @(negedge cpu_clk);
        while (!bvalid)
        begin
            cnt = cnt + 1;
            if (cnt > TIMEOUT)
                report_timeout("bvalid");
            @(negedge cpu_clk);
        end
        resp_seen = bresp;
        assert (resp_seen == exp_resp)
        else report_error($sformatf("write 0x%0h bresp %0d expected %0d",
                                    addr, resp_seen, exp_resp));
        // random hold off, response must not move and no new write may start
        delay = $unsigned($random(seed)) % 4;
        repeat (delay)
        begin
            assert (bvalid && bresp == resp_seen && !awready && !wready)
            else report_error("write response changed or readies high while pending");
            @(negedge cpu_clk);
        end
        @(posedge cpu_clk);
        bready <= 1'b1;
        @(posedge cpu_clk);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [4:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int cnt;
        int delay;
        @(posedge cpu_clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        cnt = 0;
        @(negedge cpu_clk);
        while (!arready)
        begin
            cnt = cnt + 1;
            if (cnt > TIMEOUT)
                report_timeout("arready");
            @(negedge cpu_clk);
        end
        @(posedge cpu_clk);
        arvalid <= 1'b0;
        cnt = 0;
        @(negedge cpu_clk);
        while (!rvalid)
        begin
            cnt = cnt + 1;
            if (cnt > TIMEOUT)
                report_timeout("rvalid");
            @(negedge cpu_clk);
        end
        data = rdata;
        resp = rresp;
        delay = $unsigned($random(seed)) % 4;
        repeat (delay)
        begin
            assert (rvalid && rdata == data && rresp == resp && !arready)
            else report_error("read data changed or arready high while pending");
            @(negedge cpu_clk);
        end
        @(posedge cpu_clk);
        rready <= 1'b1;
        @(posedge cpu_clk);
        rready <= 1'b0;
    endtask

    ////////////////////////////// side inputs

    // 3 cycles high, then 6 quiet cycles before the next row
    task automatic overflow_pulse();
        @(posedge cpu_clk);
        adc_ovfl <= 1'b1;
        repeat (3) @(posedge cpu_clk);
        adc_ovfl <= 1'b0;
        repeat (6) @(posedge cpu_clk);
        ovfl_pulses = ovfl_pulses + 1;
    endtask

    task automatic srq_pulse();
        @(posedge cpu_clk);
        host_srq <= 1'b1;
        @(posedge cpu_clk);
        host_srq <= 1'b0;
        srq_pending = 1'b1;
    endtask

    ////////////////////////////// table

    task automatic build_table();
        // state after reset
        add_row(OP_RD, `SDR_ADDR_CTRL, 32'h0, 32'h0, OKAY);
        add_row(OP_RD, `SDR_ADDR_STATUS, 32'h0, ID_WORD, OKAY);
        add_row(OP_RD, `SDR_ADDR_OVFL_CNT, 32'h0, 32'h0, OKAY);
        add_row(OP_RD, `SDR_ADDR_SRQ, 32'h0, 32'h0, OKAY);
        // control patterns, upper half of the write is dropped
        add_row(OP_WR, `SDR_ADDR_CTRL, 32'hA5A5_0005, 32'h0, OKAY);
        add_row(OP_RD, `SDR_ADDR_CTRL, 32'h0, 32'h0000_0005, OKAY);
        add_row(OP_WR, `SDR_ADDR_CTRL, 32'h1234_FFFA, 32'h0, OKAY);
        add_row(OP_RD, `SDR_ADDR_CTRL, 32'h0, 32'h0000_FFFA, OKAY);
        add_row(OP_WR, `SDR_ADDR_CTRL, 32'h0000_0007, 32'h0, OKAY);
        add_row(OP_RD, `SDR_ADDR_CTRL, 32'h0, 32'h0000_0007, OKAY);
        // unmapped addresses and the read only status word
        add_row(OP_WR, 5'h10, 32'h0000_0000, 32'h0, SLVERR);
        add_row(OP_RD, 5'h10, 32'h0, 32'h0, SLVERR);
        add_row(OP_RD, 5'h14, 32'h0, 32'h0, SLVERR);
        add_row(OP_WR, 5'h14, 32'h0000_FFFF, 32'h0, SLVERR);
        add_row(OP_RD, `SDR_ADDR_CTRL, 32'h0, 32'h0000_0007, OKAY);
        add_row(OP_WR, `SDR_ADDR_STATUS, 32'h0000_FFFF, 32'h0, OKAY);
        add_row(OP_RD, `SDR_ADDR_STATUS, 32'h0, ID_WORD, OKAY);
        // overflow events, then clear by write
        add_row(OP_OVF, 5'h0, 32'h0, 32'h0, OKAY);
        add_row(OP_OVF, 5'h0, 32'h0, 32'h0, OKAY);
        add_row(OP_OVF, 5'h0, 32'h0, 32'h0, OKAY);
        add_row(OP_RD, `SDR_ADDR_OVFL_CNT, 32'h0, 32'h0000_0003, OKAY);
        add_row(OP_RD, `SDR_ADDR_STATUS, 32'h0, ID_WORD | FLAG_BIT, OKAY);
        add_row(OP_WR, `SDR_ADDR_OVFL_CNT, 32'h0000_1234, 32'h0, OKAY);
        add_row(OP_RD, `SDR_ADDR_OVFL_CNT, 32'h0, 32'h0, OKAY);
        add_row(OP_RD, `SDR_ADDR_STATUS, 32'h0, ID_WORD, OKAY);
        // service request capture and read clear
        add_row(OP_SRQ, 5'h0, 32'h0, 32'h0, OKAY);
        add_row(OP_RD, `SDR_ADDR_SRQ, 32'h0, 32'h0000_0001, OKAY);
        add_row(OP_RD, `SDR_ADDR_SRQ, 32'h0, 32'h0, OKAY);
        add_row(OP_SRQ, 5'h0, 32'h0, 32'h0, OKAY);
        add_row(OP_SRQ, 5'h0, 32'h0, 32'h0, OKAY);
        add_row(OP_RD, `SDR_ADDR_SRQ, 32'h0, 32'h0000_0001, OKAY);
        add_row(OP_RD, `SDR_ADDR_SRQ, 32'h0, 32'h0, OKAY);
        add_row(OP_WR, `SDR_ADDR_CTRL, 32'h0000_0000, 32'h0, OKAY);
        add_row(OP_RD, `SDR_ADDR_CTRL, 32'h0, 32'h0, OKAY);
    endtask

    ////////////////////////////// main sequence

    initial
    begin
        logic [31:0] rd_word;
        logic [1:0]  rd_resp;
        int          i;
        cpu_clk     = 1'b0;
        rx_ovfl_rst = 1'b1;
        awvalid     = 1'b0;
        awaddr      = '0;
        wvalid      = 1'b0;
        wdata       = '0;
        wstrb       = 4'hF;
        bready      = 1'b0;
        arvalid     = 1'b0;
        araddr      = '0;
        rready      = 1'b0;
        adc_ovfl    = 1'b0;
        host_srq    = 1'b0;
        seed        = 22;
        error_count = 0;
        n_rows      = 0;
        ctrl_model  = '0;
        ovfl_pulses = 0;
        srq_pending = 1'b0;
        build_table();

        repeat (2) @(posedge cpu_clk);
        rx_ovfl_rst <= 1'b0;
        @(negedge cpu_clk);
        check_outputs();

        for (i = 0; i < n_rows; i++)
        begin
            case (row_op[i])
                OP_WR:
                begin
                    axi_write(row_addr[i], row_wdata[i], row_resp[i]);
                    if (row_addr[i] == `SDR_ADDR_CTRL)
                        ctrl_model = row_wdata[i][15:0];
                    if (row_addr[i] == `SDR_ADDR_OVFL_CNT)
                        ovfl_pulses = 0;
                    @(negedge cpu_clk);
                    check_outputs();
                end
                OP_RD:
                begin
                    axi_read(row_addr[i], rd_word, rd_resp);
                    assert (rd_resp == row_resp[i] && rd_word == row_exp[i])
                    else report_error($sformatf("row %0d read 0x%0h got 0x%08h/%0d exp 0x%08h/%0d",
                                                i, row_addr[i], rd_word, rd_resp,
                                                row_exp[i], row_resp[i]));
                    // count and capture must match what was driven
                    if (row_addr[i] == `SDR_ADDR_OVFL_CNT)
                        assert (rd_word == ovfl_pulses)
                        else report_error($sformatf("count %0d after %0d pulses",
                                                    rd_word, ovfl_pulses));
                    if (row_addr[i] == `SDR_ADDR_SRQ)
                    begin
                        assert (rd_word == {31'b0, srq_pending})
                        else report_error($sformatf("srq read %0d expected %0d",
                                                    rd_word, srq_pending));
                        srq_pending = 1'b0;
                    end
                end
                OP_OVF:
                    overflow_pulse();
                OP_SRQ:
                    srq_pulse();
                default:
                    report_error("unknown operation in stimulus table");
            endcase
        end

        if (error_count == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verif/sdr_ctrl_asserts.sv
//////////////////////////////
// protocol checks on the sdr control top
// bus checks sleep during reset, the reset exit check does not
//////////////////////////////

`timescale 1ns/10ps

module sdr_ctrl_asserts (
    input logic        cpu_clk,
    input logic        rx_ovfl_rst,
    input logic        awready,
    input logic        bvalid,
    input logic        bready,
    input logic [1:0]  bresp,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata,
    input logic        adc_clken,
    input logic        eeprom_wp,
    input logic        irq
);

    // write response held until the host takes it
    bresp_hold: assert property (@(posedge cpu_clk) disable iff (rx_ovfl_rst)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("bvalid dropped or bresp moved before bready");

    // read data held until the host takes it
    rdata_hold: assert property (@(posedge cpu_clk) disable iff (rx_ovfl_rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("rvalid dropped or rdata moved before rready");

    // one write in flight
    aw_blocked: assert property (@(posedge cpu_clk) disable iff (rx_ovfl_rst)
        bvalid |-> !awready)
        else $error("awready high with a write response pending");

    // control register comes out of reset cleared
    ctrl_after_rst: assert property (@(posedge cpu_clk)
        rx_ovfl_rst |=> !adc_clken && !eeprom_wp && !irq)
        else $error("control output high right after reset");

endmodule

bind sdr_ctrl_top sdr_ctrl_asserts asserts_i (
    .cpu_clk     (cpu_clk),
    .rx_ovfl_rst (rx_ovfl_rst),
    .awready     (awready),
    .bvalid      (bvalid),
    .bready      (bready),
    .bresp       (bresp),
    .rvalid      (rvalid),
    .rready      (rready),
    .rdata       (rdata),
    .adc_clken   (adc_clken),
    .eeprom_wp   (eeprom_wp),
    .irq         (irq)
);

// File: rtl/sdr_ctrl_top.sv
//////////////////////////////
// host control and status top for the sdr receiver
// single clock, adc_ovfl is the only asynchronous input
//////////////////////////////

`timescale 1ns/10ps

module sdr_ctrl_top
    import sdr_ctrl_pkg::*;
(
    input  logic       cpu_clk,
    input  logic       rx_ovfl_rst,

    // AXI4-Lite slave
    input  logic       awvalid,
    output logic       awready,
    input  reg_addr_t  awaddr,
    input  logic       wvalid,
    output logic       wready,
    input  reg_data_t  wdata,
    input  logic [3:0] wstrb,
    output logic       bvalid,
    input  logic       bready,
    output axil_resp_t bresp,
    input  logic       arvalid,
    output logic       arready,
    input  reg_addr_t  araddr,
    output logic       rvalid,
    input  logic       rready,
    output reg_data_t  rdata,
    output axil_resp_t rresp,

    // board signals
    input  logic       adc_ovfl,
    input  logic       host_srq,
    output logic       adc_clken,
    output logic       eeprom_wp,
    output logic       irq
);

    // register strobes
    logic      wr_en;
    reg_addr_t wr_addr;
    reg_word_t wr_data;
    logic      wr_err;
    logic      rd_en;
    reg_addr_t rd_addr;
    reg_word_t rd_data;
    logic      rd_err;

    // overflow path
    logic      ovfl_clr;
    logic      ovfl_flag;
    reg_word_t ovfl_count;

    //////////////////////////////
    // host port
    //////////////////////////////

    axil_reg_port axil_reg_port_i (
        .cpu_clk     (cpu_clk),
        .rx_ovfl_rst (rx_ovfl_rst),
        .awvalid     (awvalid),
        .awready     (awready),
        .awaddr      (awaddr),
        .wvalid      (wvalid),
        .wready      (wready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .bvalid      (bvalid),
        .bready      (bready),
        .bresp       (bresp),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .rresp       (rresp),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_err      (wr_err),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .rd_err      (rd_err)
    );

    //////////////////////////////
    // register bank
    //////////////////////////////

    ctrl_status_regs ctrl_status_regs_i (
        .cpu_clk     (cpu_clk),
        .rx_ovfl_rst (rx_ovfl_rst),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .rd_err      (rd_err),
        .wr_err      (wr_err),
        .host_srq    (host_srq),
        .ovfl_flag   (ovfl_flag),
        .ovfl_count  (ovfl_count),
        .ovfl_clr    (ovfl_clr),
        .adc_clken   (adc_clken),
        .eeprom_wp   (eeprom_wp),
        .irq         (irq)
    );

    // overflow monitor runs free of bus back-pressure
    ovfl_monitor ovfl_monitor_i (
        .cpu_clk     (cpu_clk),
        .rx_ovfl_rst (rx_ovfl_rst),
        .adc_ovfl    (adc_ovfl),
        .ovfl_clr    (ovfl_clr),
        .ovfl_flag   (ovfl_flag),
        .ovfl_count  (ovfl_count)
    );

endmodule

// File: rtl/axil_reg_port.sv
//////////////////////////////
// AXI4-Lite slave, one write and one read in flight at a time
// wstrb is not honoured, the host must write whole words
// address decode is done by the register bank
//////////////////////////////

`timescale 1ns/10ps

`include "sdr_ctrl_params.svh"

module axil_reg_port
    import sdr_ctrl_pkg::*;
(
    input  logic                     cpu_clk,
    input  logic                     rx_ovfl_rst,

    // write address channel
    input  logic                     awvalid,
    output logic                     awready,
    input  reg_addr_t                awaddr,

    // write data channel
    input  logic                     wvalid,
    output logic                     wready,
    input  reg_data_t                wdata,
    input  logic [`SDR_DATA_W/8-1:0] wstrb,

    // write response channel
    output logic                     bvalid,
    input  logic                     bready,
    output axil_resp_t               bresp,

    // read address channel
    input  logic                     arvalid,
    output logic                     arready,
    input  reg_addr_t                araddr,

    // read data channel
    output logic                     rvalid,
    input  logic                     rready,
    output reg_data_t                rdata,
    output axil_resp_t               rresp,

    // register bank side
    output logic                     wr_en,
    output reg_addr_t                wr_addr,
    output reg_word_t                wr_data,
    input  logic                     wr_err,
    output logic                     rd_en,
    output reg_addr_t                rd_addr,
    input  reg_word_t                rd_data,
    input  logic                     rd_err
);

    wr_state_t wr_state;
    rd_state_t rd_state;

    //////////////////////////////
    // write channel
    //////////////////////////////

    // both readies only while idle, a pending response blocks new writes
    assign awready = (wr_state == WR_IDLE);
    assign wready  = (wr_state == WR_IDLE);

    // accept only when address and data arrive together
    assign wr_en   = awvalid && wvalid && awready && wready;
    assign wr_addr = awaddr;
    // registers are 16 bits wide, upper data bits dropped
    assign wr_data = wdata[15:0];

    always_ff @(posedge cpu_clk)
    begin
        if (rx_ovfl_rst)
        begin
            wr_state <= WR_IDLE;
        end
        else
        begin
            case (wr_state)
                WR_IDLE:
                begin
                    if (wr_en)
                    begin
                        wr_state <= WR_RESP;
                    end
                end
                WR_RESP:
                begin
                    // hold bvalid until the host takes it
                    if (bready)
                    begin
                        wr_state <= WR_IDLE;
                    end
                end
                default:
                begin
                    wr_state <= WR_IDLE;
                end
            endcase
        end
    end

    // response code captured at acceptance
    always_ff @(posedge cpu_clk)
    begin
        if (wr_en)
        begin
            bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

    assign bvalid = (wr_state == WR_RESP);

    //////////////////////////////
    // read channel
    //////////////////////////////

    assign arready = (rd_state == RD_IDLE);
    assign rd_en   = arvalid && arready;
    assign rd_addr = araddr;

    always_ff @(posedge cpu_clk)
    begin
        if (rx_ovfl_rst)
        begin
            rd_state <= RD_IDLE;
        end
        else
        begin
            case (rd_state)
                RD_IDLE:
                begin
                    if (rd_en)
                    begin
                        rd_state <= RD_RESP;
                    end
                end
                RD_RESP:
                begin
                    if (rready)
                    begin
                        rd_state <= RD_IDLE;
                    end
                end
                default:
                begin
                    rd_state <= RD_IDLE;
                end
            endcase
        end
    end

    // bank answers combinationally, sample it once so rdata stays stable
    always_ff @(posedge cpu_clk)
    begin
        if (rd_en)
        begin
            rdata <= {{(`SDR_DATA_W - 16){1'b0}}, rd_data};
            rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

    assign rvalid = (rd_state == RD_RESP);

endmodule

// File: rtl/ctrl_status_regs.sv
//////////////////////////////
// control, status, overflow count and service request registers
// strobes are single cycle, read data answers in the same cycle
// SRQ read has a side effect, it restarts the capture
//////////////////////////////

`timescale 1ns/10ps

`include "sdr_ctrl_params.svh"

module ctrl_status_regs
    import sdr_ctrl_pkg::*;
(
    input  logic      cpu_clk,
    input  logic      rx_ovfl_rst,

    // strobes from the host port
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  reg_word_t wr_data,
    input  logic      rd_en,
    input  reg_addr_t rd_addr,
    output reg_word_t rd_data,
    output logic      rd_err,
    output logic      wr_err,

    // service request pulse, already on cpu_clk
    input  logic      host_srq,

    // overflow monitor
    input  logic      ovfl_flag,
    input  reg_word_t ovfl_count,
    output logic      ovfl_clr,

    // control outputs
    output logic      adc_clken,
    output logic      eeprom_wp,
    output logic      irq
);

    reg_word_t ctrl_reg;
    reg_word_t status_word;
    logic      srq_noted;
    logic      srq_rd;

    //////////////////////////////
    // write side
    //////////////////////////////

    // status and srq accept writes silently, only unmapped addresses fail
    always_comb
    begin
        case (wr_addr)
            `SDR_ADDR_CTRL,
            `SDR_ADDR_STATUS,
            `SDR_ADDR_OVFL_CNT,
            `SDR_ADDR_SRQ:
                wr_err = 1'b0;
            default:
                wr_err = 1'b1;
        endcase
    end

    always_ff @(posedge cpu_clk)
    begin
        if (rx_ovfl_rst)
        begin
            ctrl_reg <= '0;
        end
        else if (wr_en && (wr_addr == `SDR_ADDR_CTRL))
        begin
            ctrl_reg <= wr_data;
        end
    end

    // any write to the count register clears count and flag
    assign ovfl_clr = wr_en && (wr_addr == `SDR_ADDR_OVFL_CNT);

    assign adc_clken = ctrl_reg[`SDR_CTRL_OSC_EN];
    assign eeprom_wp = ctrl_reg[`SDR_CTRL_EEPROM_WP];
    assign irq       = ctrl_reg[`SDR_CTRL_INTERRUPT];

    //////////////////////////////
    // service request capture
    //////////////////////////////

    assign srq_rd = rd_en && (rd_addr == `SDR_ADDR_SRQ);

    // on a read the noted bit is returned and capture restarts
    // a pulse in the read cycle itself lands in the fresh capture
    always_ff @(posedge cpu_clk)
    begin
        if (rx_ovfl_rst)
        begin
            srq_noted <= 1'b0;
        end
        else if (srq_rd)
        begin
            srq_noted <= host_srq;
        end
        else
        begin
            srq_noted <= srq_noted | host_srq;
        end
    end

    //////////////////////////////
    // read side
    //////////////////////////////

    // sticky flag on top, then version, clock id, fpga id
    assign status_word = {ovfl_flag, 3'b000, `SDR_FPGA_VER, `SDR_CLOCK_ID, `SDR_FPGA_ID};

    always_comb
    begin
        rd_data = '0;
        rd_err  = 1'b0;
        case (rd_addr)
            `SDR_ADDR_CTRL:     rd_data = ctrl_reg;
            `SDR_ADDR_STATUS:   rd_data = status_word;
            `SDR_ADDR_OVFL_CNT: rd_data = ovfl_count;
            `SDR_ADDR_SRQ:      rd_data = {15'b0, srq_noted};
            // unmapped, data stays zero
            default:            rd_err  = 1'b1;
        endcase
    end

endmodule

// File: rtl/ovfl_monitor.sv
//////////////////////////////
// adc overflow synchronizer and event counter
// input pulses need two cycles high and two cycles low
// flag and count move three cycles after first sample
//////////////////////////////

`timescale 1ns/10ps

module ovfl_monitor
    import sdr_ctrl_pkg::*;
(
    input  logic      cpu_clk,
    input  logic      rx_ovfl_rst,
    input  logic      adc_ovfl,
    input  logic      ovfl_clr,
    output logic      ovfl_flag,
    output reg_word_t ovfl_count
);

    logic ovfl_meta;
    logic ovfl_sync;
    logic ovfl_sync_d;
    logic ovfl_evt;

    // two flop synchronizer, then one more stage for the edge compare
    always_ff @(posedge cpu_clk)
    begin
        if (rx_ovfl_rst)
        begin
            ovfl_meta   <= 1'b0;
            ovfl_sync   <= 1'b0;
            ovfl_sync_d <= 1'b0;
            ovfl_evt    <= 1'b0;
        end
        else
        begin
            ovfl_meta   <= adc_ovfl;
            ovfl_sync   <= ovfl_meta;
            ovfl_sync_d <= ovfl_sync;
            // registered rising edge pulse
            ovfl_evt    <= ovfl_sync & ~ovfl_sync_d;
        end
    end

    // sticky flag and saturating count, clear beats a coincident event
    always_ff @(posedge cpu_clk)
    begin
        if (rx_ovfl_rst || ovfl_clr)
        begin
            ovfl_flag  <= 1'b0;
            ovfl_count <= '0;
        end
        else if (ovfl_evt)
        begin
            ovfl_flag <= 1'b1;
            // stop at all ones
            if (ovfl_count != 16'hFFFF)
            begin
                ovfl_count <= ovfl_count + 16'd1;
            end
        end
    end

endmodule

// File: rtl/sdr_ctrl_pkg.sv
//////////////////////////////
// shared types for the sdr host control block
// widths must agree with the params header
//////////////////////////////

package sdr_ctrl_pkg;

    // byte address on the register bus
    typedef logic [4:0] reg_addr_t;

    // full AXI data word
    typedef logic [31:0] reg_data_t;

    // register content, low half of the data word
    typedef logic [15:0] reg_word_t;

    // AXI response code
    typedef logic [1:0] axil_resp_t;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    // write channel, one transaction in flight
    typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;

    // read channel, independent of the write side
    typedef enum logic {RD_IDLE, RD_RESP} rd_state_t;

endpackage

// File: rtl/sdr_ctrl_params.svh
//////////////////////////////
// build constants for the sdr host control block
// registers hold 16 bits, the upper data bits read as zero
// identifiers are fixed per bitstream, change them here only
//////////////////////////////

`ifndef SDR_CTRL_PARAMS_SVH
`define SDR_CTRL_PARAMS_SVH

// bus widths
`define SDR_DATA_W          32
`define SDR_ADDR_W          5

// register byte addresses, anything else is a decode error
`define SDR_ADDR_CTRL       5'h00
`define SDR_ADDR_STATUS     5'h04
`define SDR_ADDR_OVFL_CNT   5'h08
`define SDR_ADDR_SRQ        5'h0C

// control register bit positions
`define SDR_CTRL_OSC_EN     0
`define SDR_CTRL_EEPROM_WP  1
`define SDR_CTRL_INTERRUPT  2

// build identifiers packed into the status word
`define SDR_FPGA_VER        4'd3
`define SDR_CLOCK_ID        4'd0
`define SDR_FPGA_ID         4'd1

`endif
